// File: logic/lsu_isa_pkg.sv
/* RV32I memory instruction encodings
   Opcodes and funct3 codes for the loads and stores the unit handles */
package lsu_isa_pkg;

    // Major opcodes, bits [6:0] of the instruction
    localparam logic [6:0] opcode_load  = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    // funct3 for loads and stores
    // Bit 2 selects zero extension on loads, bits [1:0] give the size
    localparam logic [2:0] f3_byte   = 3'b000;  // LB / SB
    localparam logic [2:0] f3_half   = 3'b001;  // LH / SH
    localparam logic [2:0] f3_word   = 3'b010;  // LW / SW
    localparam logic [2:0] f3_byte_u = 3'b100;  // LBU
    localparam logic [2:0] f3_half_u = 3'b101;  // LHU

    // Stores only take the signed forms
    function automatic logic legal_store_f3(input logic [2:0] f3);
        return (f3 == f3_byte) || (f3 == f3_half) || (f3 == f3_word);
    endfunction

    function automatic logic legal_load_f3(input logic [2:0] f3);
        logic legal;
        legal = legal_store_f3(f3);
        legal = legal || (f3 == f3_byte_u) || (f3 == f3_half_u);
        return legal;
    endfunction

endpackage

// File: logic/lsu_mem_pkg.sv
/* Data memory access description
   Access kind, byte lane mask and word geometry shared by decode, memory and load path */
package lsu_mem_pkg;

    localparam int lanes_per_word = 4;
    localparam int lane_bits      = 8;
    localparam int word_bits      = lanes_per_word * lane_bits;

    // What the memory does in a cycle
    typedef enum logic [1:0] {
        acc_none  = 2'd0,
        acc_read  = 2'd1,
        acc_write = 2'd2
    } access_kind_t;

    // One bit per byte lane, bit 0 is the least significant lane
    typedef logic [lanes_per_word-1:0] frame_mask_t;

    typedef logic [word_bits-1:0] word_t;

endpackage

// File: logic/lsu_access_decode.sv
/* Request decode for the load/store unit
   Turns opcode, funct3 and address into access kind, lane mask, word index and aligned data */
module lsu_access_decode
    import lsu_isa_pkg::*;
    import lsu_mem_pkg::*;
#(
    parameter int ADDRESS_WIDTH = 8
)
(
    input  logic                     req,
    input  logic [6:0]               opcode,
    input  logic [2:0]               funct3,
    input  word_t                    address,
    input  word_t                    store_data,
    output access_kind_t             kind,
    output frame_mask_t              frame_mask,
    output logic [ADDRESS_WIDTH-1:0] word_index,
    output word_t                    wdata,
    output logic [1:0]               lane_offset,
    output logic [2:0]               load_funct3,
    output logic                     fault
);

    logic is_load;
    logic is_store;
    logic legal;
    frame_mask_t size_mask;  // Lanes covered at offset 0

    assign is_load  = (opcode == opcode_load);
    assign is_store = (opcode == opcode_store);

    assign legal = (is_load && legal_load_f3(funct3)) || (is_store && legal_store_f3(funct3));

    // Size from funct3[1:0], sign bit does not matter here
    always_comb
    begin
        case (funct3[1:0])
            f3_byte[1:0]:
            begin
                size_mask   = frame_mask_t'(4'b0001);
                lane_offset = address[1:0];
            end
            f3_half[1:0]:
            begin
                size_mask   = frame_mask_t'(4'b0011);
                lane_offset = {address[1], 1'b0};  // Bit 0 dropped
            end
            default:
            begin
                size_mask   = frame_mask_t'(4'b1111);
                lane_offset = 2'b00;
            end
        endcase
    end

    always_comb
    begin
        kind = acc_none;
        if (req && legal)
            kind = is_store ? acc_write : acc_read;
    end

    assign frame_mask = (kind == acc_none) ? '0 : frame_mask_t'(size_mask << lane_offset);

    // Word address, upper bits beyond the depth wrap
    assign word_index = address[ADDRESS_WIDTH+1:2];

    assign wdata       = store_data << (lane_bits * int'(lane_offset));  // Move into target lanes
    assign load_funct3 = funct3;

    // Memory opcode with an unsupported size
    assign fault = req && (is_load || is_store) && !legal;

endmodule

// File: logic/data_memory.sv
/* Byte-lane data memory
   Word array with per-lane write enables and a registered read port */
module data_memory
    import lsu_mem_pkg::*;
#(
    parameter int ADDRESS_WIDTH = 8
)
(
    input  logic                     memory_done,
    input  logic                     rst_n,
    input  access_kind_t             kind,
    input  frame_mask_t              frame_mask,
    input  logic [ADDRESS_WIDTH-1:0] word_index,
    input  word_t                    wdata,
    output word_t                    rdata,
    output logic                     read_valid
);

    localparam int depth = 2 ** ADDRESS_WIDTH;

    word_t mem [depth];

    logic write_en;
    logic read_en;

    assign write_en = (kind == acc_write);
    assign read_en  = (kind == acc_read);

    // Only the masked lanes are written
    always_ff @(posedge memory_done)
    begin
        if (write_en)
        begin
            for (int i = 0; i < lanes_per_word; i++)
            begin
                if (frame_mask[i])
                    mem[word_index][i*lane_bits +: lane_bits] <= wdata[i*lane_bits +: lane_bits];
            end
        end
    end

    // Full word is read, load path picks the lane
    always_ff @(posedge memory_done)
    begin
        if (read_en)
            rdata <= mem[word_index];
    end

    always_ff @(posedge memory_done)
    begin
        if (!rst_n)
            read_valid <= 1'b0;
        else
            read_valid <= read_en;
    end

endmodule

// File: logic/load_align.sv
/* Load result alignment
   Shifts the read word down to its lane, extends it and registers the load and fault strobes */
module load_align
    import lsu_isa_pkg::*;
    import lsu_mem_pkg::*;
(
    input  logic       memory_done,
    input  logic       rst_n,
    input  logic [2:0] load_funct3,
    input  logic [1:0] lane_offset,
    input  logic       fault_in,
    input  word_t      rdata,
    input  logic       read_valid,
    output word_t      load_data,
    output logic       load_valid,
    output logic       fault
);

    logic [2:0] funct3_q;  // Lines up with rdata
    logic [1:0] offset_q;
    logic       fault_q;
    word_t      shifted;
    word_t      extended;

    always_ff @(posedge memory_done)
    begin
        funct3_q <= load_funct3;
        offset_q <= lane_offset;
    end

    assign shifted = rdata >> (lane_bits * int'(offset_q));

    always_comb
    begin
        case (funct3_q)
            f3_byte:   extended = {{(word_bits-lane_bits){shifted[lane_bits-1]}},
                                   shifted[lane_bits-1:0]};
            f3_half:   extended = {{(word_bits-2*lane_bits){shifted[2*lane_bits-1]}},
                                   shifted[2*lane_bits-1:0]};
            f3_byte_u: extended = {{(word_bits-lane_bits){1'b0}}, shifted[lane_bits-1:0]};
            f3_half_u: extended = {{(word_bits-2*lane_bits){1'b0}}, shifted[2*lane_bits-1:0]};
            default:   extended = shifted;  // LW
        endcase
    end

    // Output stage, fault takes two registers to match the load latency
    always_ff @(posedge memory_done)
    begin
        if (!rst_n)
        begin
            fault_q    <= 1'b0;
            fault      <= 1'b0;
            load_valid <= 1'b0;
            load_data  <= '0;
        end
        else
        begin
            fault_q    <= fault_in;
            fault      <= fault_q;
            load_valid <= read_valid;
            if (read_valid)
                load_data <= extended;  // Hold last result otherwise
        end
    end

endmodule

// File: logic/load_store_unit.sv
/* RISC-V load/store unit
   Request decode, byte-lane data memory and load alignment */
module load_store_unit
    import lsu_mem_pkg::*;
#(
    parameter int ADDRESS_WIDTH = 8
)
(
    input  logic       memory_done,
    input  logic       rst_n,
    input  logic       req,
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  word_t      address,
    input  word_t      store_data,
    output word_t      load_data,
    output logic       load_valid,
    output logic       fault
);

    access_kind_t             kind;
    frame_mask_t              frame_mask;
    logic [ADDRESS_WIDTH-1:0] word_index;
    word_t                    wdata;
    logic [1:0]               lane_offset;
    logic [2:0]               load_funct3;
    logic                     decode_fault;
    word_t                    rdata;
    logic                     read_valid;

    lsu_access_decode #(
        .ADDRESS_WIDTH (ADDRESS_WIDTH)
    ) u_decode (
        .req         (req),
        .opcode      (opcode),
        .funct3      (funct3),
        .address     (address),
        .store_data  (store_data),
        .kind        (kind),
        .frame_mask  (frame_mask),
        .word_index  (word_index),
        .wdata       (wdata),
        .lane_offset (lane_offset),
        .load_funct3 (load_funct3),
        .fault       (decode_fault)
    );

    data_memory #(
        .ADDRESS_WIDTH (ADDRESS_WIDTH)
    ) u_memory (
        .memory_done (memory_done),
        .rst_n       (rst_n),
        .kind        (kind),
        .frame_mask  (frame_mask),
        .word_index  (word_index),
        .wdata       (wdata),
        .rdata       (rdata),
        .read_valid  (read_valid)
    );

    load_align u_align (
        .memory_done (memory_done),
        .rst_n       (rst_n),
        .load_funct3 (load_funct3),
        .lane_offset (lane_offset),
        .fault_in    (decode_fault),
        .rdata       (rdata),
        .read_valid  (read_valid),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .fault       (fault)
    );

endmodule

// File: dv/lsu_clock_gen.sv
/* Testbench clock and reset source for the load/store unit */
module lsu_clock_gen #(
    parameter int period       = 4,
    parameter int reset_cycles = 2
)
(
    input  logic hold_reset,
    output logic memory_done,
    output logic rst_n
);

    logic por_done;  // Power-on reset over

    initial
    begin
        memory_done = 1'b0;
        forever #(period / 2) memory_done = ~memory_done;
    end

    initial
    begin
        por_done = 1'b0;
        repeat (reset_cycles) @(posedge memory_done);
        #1;
        por_done = 1'b1;
    end

    assign rst_n = por_done && !hold_reset;  // Testbench may pull reset mid-run

endmodule

// File: dv/lsu_tb.sv
/* Load/store unit testbench
   Drives requests, predicts results from a byte model and checks strobes and data */
module lsu_tb
    import lsu_isa_pkg::*;
    import lsu_mem_pkg::*;
();

    localparam int address_width  = 8;
    localparam int n_words        = 2 ** address_width;
    localparam int n_bytes        = n_words * lanes_per_word;
    localparam int t1_requests    = 2 * n_words + 32;
    localparam int t4_requests    = 200;
    localparam int total_requests = t1_requests + 64 + 64 + t4_requests + 17 + 16;
    localparam int cycle_limit    = 4 * total_requests + 50;

    // One expected result strobe, tagged with the request cycle
    typedef struct packed {
        int    cycle;
        logic  load;
        logic  fault;
        word_t data;
    } expect_t;

    logic       memory_done;
    logic       rst_n;
    logic       hold_reset;
    logic       req;
    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      address;
    word_t      store_data;
    word_t      load_data;
    logic       load_valid;
    logic       fault;

    logic [7:0] mem_model [n_bytes];  // Byte image of the DUT memory
    expect_t    expect_q [$];
    int         cycle;
    int         checks;
    int         errors;
    int         tests_run;
    int         tests_failed;

    lsu_clock_gen #(
        .period       (4),
        .reset_cycles (2)
    ) clock0 (
        .hold_reset  (hold_reset),
        .memory_done (memory_done),
        .rst_n       (rst_n)
    );

    load_store_unit #(
        .ADDRESS_WIDTH (address_width)
    ) dut0 (
        .memory_done (memory_done),
        .rst_n       (rst_n),
        .req         (req),
        .opcode      (opcode),
        .funct3      (funct3),
        .address     (address),
        .store_data  (store_data),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .fault       (fault)
    );

    function automatic int access_bytes(input logic [2:0] f3);
        case (f3[1:0])
            2'b00:   return 1;
            2'b01:   return 2;
            default: return 4;
        endcase
    endfunction

    // Byte address inside the memory, upper bits wrap, low bits cleared to the size
    function automatic int aligned_byte(input logic [2:0] f3, input word_t addr);
        int a;
        a = int'(addr[address_width+1:0]);
        return a - (a % access_bytes(f3));
    endfunction

    function automatic logic legal_access(input logic [6:0] op, input logic [2:0] f3);
        if (op == opcode_store)
            return (f3 == f3_byte) || (f3 == f3_half) || (f3 == f3_word);
        return (f3 == f3_byte) || (f3 == f3_half) || (f3 == f3_word)
            || (f3 == f3_byte_u) || (f3 == f3_half_u);
    endfunction

    // Expected load value from the byte model
    function automatic word_t expected_load(input logic [2:0] f3, input word_t addr);
        int    base;
        word_t raw;
        base = aligned_byte(f3, addr);
        raw  = '0;
        for (int i = 0; i < access_bytes(f3); i++)
            raw[8*i +: 8] = mem_model[base + i];
        case (f3)
            f3_byte: return {{24{raw[7]}}, raw[7:0]};
            f3_half: return {{16{raw[15]}}, raw[15:0]};
            default: return raw;  // Unsigned forms are already zero filled
        endcase
    endfunction

    task automatic store_to_model(input logic [2:0] f3, input word_t addr, input word_t data);
        int base;
        base = aligned_byte(f3, addr);
        for (int i = 0; i < access_bytes(f3); i++)
            mem_model[base + i] = data[8*i +: 8];  // Low bytes of store data go out
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED at time %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    // One request strobe in the next cycle, expectation queued for cycle + 2
    task automatic issue_request(input logic [6:0] op, input logic [2:0] f3,
                                 input word_t addr, input word_t data);
        expect_t e;
        @(posedge memory_done);
        #1;
        req        = 1'b1;
        opcode     = op;
        funct3     = f3;
        address    = addr;
        store_data = data;
        if (op != opcode_load && op != opcode_store)
            return;  // Not a memory request
        e       = '0;
        e.cycle = cycle;
        if (!legal_access(op, f3))
            e.fault = 1'b1;
        else if (op == opcode_load)
        begin
            e.load = 1'b1;
            e.data = expected_load(f3, addr);
        end
        else
            store_to_model(f3, addr, data);
        if (e.load || e.fault)
            expect_q.push_back(e);
    endtask

    task automatic finish_test(input int id, input string name, input int errors_before);
        @(posedge memory_done);
        #1;
        req = 1'b0;
        while (expect_q.size() != 0)
            @(posedge memory_done);
        repeat (2) @(posedge memory_done);
        tests_run++;
        if (errors != errors_before)
        begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", id, name, errors - errors_before);
        end
        else
            $display("Test %0d %s: ok", id, name);
    endtask

    always @(posedge memory_done)
    begin
        cycle = cycle + 1;
        if (cycle > cycle_limit)
        begin
            $display("Timeout: run stopped after %0d cycles with results still missing", cycle);
            $display("Test failures found");
            $finish;
        end
    end

    // Strobes are stable mid-cycle
    always @(negedge memory_done)
    begin
        expect_t e;
        e = '0;
        if (expect_q.size() != 0 && expect_q[0].cycle == cycle - 2)
            e = expect_q.pop_front();
        if (cycle > 0)
        begin
            check_bit("load_valid", e.load, load_valid);
            check_bit("fault", e.fault, fault);
            if (e.load)
                check_word("load_data", e.data, load_data);
        end
        if (!rst_n)
            expect_q.delete();  // In-flight requests die with reset
    end

    initial
    begin
        int unsigned seed;
        int unsigned sel;
        int          base_errors;
        word_t       r;
        word_t       addr;
        logic [2:0]  f3;
        cycle        = 0;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        hold_reset   = 1'b0;
        req          = 1'b0;
        opcode       = '0;
        funct3       = '0;
        address      = '0;
        store_data   = '0;
        seed         = $urandom(32'h5c2a);
        wait (rst_n === 1'b1);

        base_errors = errors;
        for (int w = 0; w < n_words; w++)
            issue_request(opcode_store, f3_word, word_t'(w * 4), $urandom());
        for (int w = 0; w < n_words; w++)
            issue_request(opcode_load, f3_word, word_t'(w * 4), '0);
        for (int k = 0; k < 16; k++)
            issue_request(opcode_load, f3_word, word_t'(k * 4 + (k + 1) * n_bytes), '0);
        for (int k = 0; k < 8; k++)
        begin
            issue_request(opcode_store, f3_word, word_t'(k * 4 + (k + 3) * n_bytes), $urandom());
            issue_request(opcode_load, f3_word, word_t'(k * 4), '0);
        end
        finish_test(1, "word store and load", base_errors);

        base_errors = errors;
        for (int w = 16; w < 20; w++)
        begin
            for (int off = 0; off < 4; off++)
            begin
                r    = $urandom();
                r[7] = off[0];  // Both sign cases
                issue_request(opcode_store, f3_byte, word_t'(w * 4 + off), r);
                issue_request(opcode_load, f3_word, word_t'(w * 4), '0);
            end
            for (int off = 0; off < 4; off++)
            begin
                issue_request(opcode_load, f3_byte, word_t'(w * 4 + off), '0);
                issue_request(opcode_load, f3_byte_u, word_t'(w * 4 + off), '0);
            end
        end
        finish_test(2, "byte lanes", base_errors);

        base_errors = errors;
        for (int w = 24; w < 28; w++)
        begin
            for (int off = 0; off < 4; off++)
            begin
                r     = $urandom();
                r[15] = off[0];
                issue_request(opcode_store, f3_half, word_t'(w * 4 + off), r);
                issue_request(opcode_load, f3_half, word_t'(w * 4 + off), '0);
                issue_request(opcode_load, f3_half_u, word_t'(w * 4 + off), '0);
                issue_request(opcode_load, f3_word, word_t'(w * 4), '0);
            end
        end
        finish_test(3, "halfword lanes", base_errors);

        base_errors = errors;
        for (int i = 0; i < t4_requests; i++)
        begin
            sel  = $urandom_range(7, 0);
            addr = $urandom() & 32'hffff_fc1f;  // Words 0 to 7, high bits wrap
            case (sel)
                0, 3:    f3 = f3_byte;
                1, 4:    f3 = f3_half;
                2, 5:    f3 = f3_word;
                6:       f3 = f3_byte_u;
                default: f3 = f3_half_u;
            endcase
            issue_request((sel < 3) ? opcode_store : opcode_load, f3, addr, $urandom());
        end
        finish_test(4, "random back-to-back mix", base_errors);

        base_errors = errors;
        for (int f = 0; f < 8; f++)
        begin
            if (!legal_access(opcode_load, 3'(f)))
                issue_request(opcode_load, 3'(f), word_t'(30 * 4), '0);
        end
        for (int f = 0; f < 8; f++)
        begin
            if (!legal_access(opcode_store, 3'(f)))
            begin
                issue_request(opcode_store, 3'(f), word_t'(30 * 4), $urandom());
                issue_request(opcode_load, f3_word, word_t'(30 * 4), '0);
            end
        end
        issue_request(7'b0110011, f3_word, word_t'(30 * 4), $urandom());  // OP
        issue_request(opcode_load, f3_word, word_t'(30 * 4), '0);
        issue_request(7'b0010011, f3_byte, word_t'(30 * 4), $urandom());  // OP-IMM
        issue_request(opcode_load, f3_word, word_t'(30 * 4), '0);
        finish_test(5, "illegal and foreign requests", base_errors);

        base_errors = errors;
        for (int w = 0; w < 5; w++)
            issue_request(opcode_load, f3_word, word_t'(w * 4), '0);
        issue_request(opcode_load, 3'b011, word_t'(18), '0);  // Faulting load cut off by reset
        hold_reset = 1'b1;
        @(posedge memory_done);
        #1;
        req        = 1'b0;
        hold_reset = 1'b0;
        for (int w = 0; w < 8; w++)
            issue_request(opcode_load, f3_word, word_t'(w * 4), '0);
        issue_request(opcode_store, f3_byte, word_t'(9), $urandom());
        issue_request(opcode_load, f3_word, word_t'(8), '0);
        finish_test(6, "reset mid-stream", base_errors);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: flist.f
logic/lsu_isa_pkg.sv
logic/lsu_mem_pkg.sv
logic/lsu_access_decode.sv
logic/data_memory.sv
logic/load_align.sv
logic/load_store_unit.sv
dv/lsu_clock_gen.sv
dv/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the load/store unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module lsu_tb -o lsu_sim \
    && ./obj_dir/lsu_sim | tee /dev/stderr | grep -qF "All tests passed!" \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
